/* verilog/mipsPkg.sv */
`default_nettype none

package mipsPkg;

	////////////////////
	// Sizes
	////////////////////
	localparam int ImemWords   = 64;
	localparam int DmemWords   = 64;
	localparam int QueueDepth  = 8;
	localparam int LoadCredits = 4;
	localparam int ImemAw      = $clog2(ImemWords);
	localparam int DmemAw      = $clog2(DmemWords);
	localparam int QueueAw     = $clog2(QueueDepth);
	localparam int LoadCw      = $clog2(LoadCredits + 1);
	// Consumer may bank a long run of credits
	localparam int CreditW     = 8;

	////////////////////
	// Instruction fields
	////////////////////
	typedef enum logic [5:0] {
		Special = 6'b000000,
		J       = 6'b000001,
		Jal     = 6'b000011,
		Beq     = 6'b000100,
		Ori     = 6'b001101,
		Lui     = 6'b001111,
		Lw      = 6'b100011,
		Sw      = 6'b101011,
		Halt    = 6'b111110,
		Ras     = 6'b111111
	} opcodeE;

	typedef enum logic [5:0] {
		Add = 6'b100000,
		Sub = 6'b100010,
		Jr  = 6'b001000
	} funcE;

	////////////////////
	// Control encodings
	////////////////////
	typedef enum logic [1:0] {Rt = 2'd0, Rd = 2'd1, Ra = 2'd2} regDstE;

	typedef enum logic [2:0] {
		AluAdd = 3'd0,
		AluSub = 3'd1,
		AluOr  = 3'd2,
		AluRot = 3'd4
	} aluOpE;

	typedef enum logic [1:0] {WbAlu = 2'd0, WbMem = 2'd1, WbLink = 2'd2, WbLui = 2'd3} wbSelE;

	typedef enum logic [1:0] {NpcSeq = 2'd0, NpcJump = 2'd1, NpcBranch = 2'd2, NpcReg = 2'd3} npcOpE;

	typedef struct packed {
		regDstE regDst;
		logic   regWrite;
		logic   extSigned;
		logic   aluSrcImm;
		aluOpE  aluOp;
		logic   memWrite;
		wbSelE  wbSel;
		npcOpE  npcOp;
		logic   halt;
	} ctrlT;

	typedef struct packed {
		logic [ImemAw-1:0] addr;
		logic [31:0]       instr;
	} loadWordT;

	// One record per retired instruction
	typedef struct packed {
		logic [31:0] pc;
		logic [31:0] instr;
		logic        regWe;
		logic [4:0]  regNum;
		logic [31:0] regVal;
		logic        memWe;
		logic [31:0] memAddr;
		logic [31:0] memData;
	} traceT;

endpackage

`default_nettype wire

/* verilog/ctrlDecode.sv */
`timescale 1ns/1ps
`default_nettype none

module ctrlDecode (
	input  logic [5:0]    op,
	input  logic [5:0]    func,
	output mipsPkg::ctrlT ctrl
);

	always_comb begin
		// Safe default, no writes and fall through
		ctrl = '0;
		ctrl.regDst = mipsPkg::Rt;
		ctrl.aluOp = mipsPkg::AluAdd;
		ctrl.wbSel = mipsPkg::WbAlu;
		ctrl.npcOp = mipsPkg::NpcSeq;

		case (op)
			mipsPkg::Special: begin
				case (func)
					mipsPkg::Add: begin
						ctrl.regDst = mipsPkg::Rd;
						ctrl.regWrite = 1'b1;
					end
					mipsPkg::Sub: begin
						ctrl.regDst = mipsPkg::Rd;
						ctrl.regWrite = 1'b1;
						ctrl.aluOp = mipsPkg::AluSub;
					end
					mipsPkg::Jr: ctrl.npcOp = mipsPkg::NpcReg;
					default: ;
				endcase
			end
			mipsPkg::Ori: begin
				ctrl.regWrite = 1'b1;
				ctrl.aluSrcImm = 1'b1;
				ctrl.aluOp = mipsPkg::AluOr;
			end
			mipsPkg::Lw: begin
				ctrl.regWrite = 1'b1;
				ctrl.extSigned = 1'b1;
				ctrl.aluSrcImm = 1'b1;
				ctrl.wbSel = mipsPkg::WbMem;
			end
			mipsPkg::Sw: begin
				ctrl.extSigned = 1'b1;
				ctrl.aluSrcImm = 1'b1;
				ctrl.memWrite = 1'b1;
			end
			mipsPkg::Beq: ctrl.npcOp = mipsPkg::NpcBranch;
			mipsPkg::Lui: begin
				ctrl.regWrite = 1'b1;
				ctrl.aluSrcImm = 1'b1;
				ctrl.wbSel = mipsPkg::WbLui;
			end
			mipsPkg::Jal: begin
				ctrl.regDst = mipsPkg::Ra;
				ctrl.regWrite = 1'b1;
				ctrl.wbSel = mipsPkg::WbLink;
				ctrl.npcOp = mipsPkg::NpcJump;
			end
			mipsPkg::J: ctrl.npcOp = mipsPkg::NpcJump;
			// Rotate rs by imm[4:0] into rt
			mipsPkg::Ras: begin
				ctrl.regWrite = 1'b1;
				ctrl.aluSrcImm = 1'b1;
				ctrl.aluOp = mipsPkg::AluRot;
			end
			mipsPkg::Halt: ctrl.halt = 1'b1;
			default: ;
		endcase
	end

endmodule

`default_nettype wire

/* verilog/progLoader.sv */
`timescale 1ns/1ps
`default_nettype none

module progLoader (
	input  logic                       clk,
	input  logic                       rst,
	input  logic                       loadValid,
	input  mipsPkg::loadWordT          loadWord,
	output logic                       loadCredit,
	output logic                       imemWe,
	output logic [mipsPkg::ImemAw-1:0] imemAddr,
	output logic [31:0]                imemData
);

	// Mirror of the sender's credit count
	logic [mipsPkg::LoadCw-1:0] senderCredits;

	////////////////////
	// Write strobe and credit return
	////////////////////
	always_ff @(posedge clk) begin
		if (rst) begin
			imemWe <= 1'b0;
			loadCredit <= 1'b0;
		end else begin
			imemWe <= loadValid;
			// Credit goes back once the word is in memory
			loadCredit <= imemWe;
		end
	end

	always_ff @(posedge clk) begin
		if (loadValid) begin
			imemAddr <= loadWord.addr;
			imemData <= loadWord.instr;
		end
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			senderCredits <= mipsPkg::LoadCw'(mipsPkg::LoadCredits);
		end else if (loadValid && !loadCredit) begin
			senderCredits <= senderCredits - 1'b1;
		end else if (!loadValid && loadCredit) begin
			senderCredits <= senderCredits + 1'b1;
		end
	end

	// Sender must never spend a credit it does not hold
	loadCreditCheck: assert property (@(posedge clk) disable iff (rst)
		loadValid |-> senderCredits != '0)
		else $error("progLoader: load beat with no credit left");

endmodule

`default_nettype wire

/* verilog/execCore.sv */
`timescale 1ns/1ps
`default_nettype none

module execCore (
	input  logic                       clk,
	input  logic                       rst,
	input  logic                       start,
	input  logic                       full,
	input  logic [31:0]                instr,
	output logic [mipsPkg::ImemAw-1:0] fetchAddr,
	output logic                       recValid,
	output mipsPkg::traceT             rec,
	output logic                       done
);

	mipsPkg::ctrlT ctrl;
	logic [31:0] pc;
	logic [31:0] pcPlus4;
	logic [31:0] nextPc;
	logic running;
	logic retire;
	logic [31:0] regFile [32];
	logic [31:0] dmem [mipsPkg::DmemWords];
	logic [4:0] dest;
	logic [31:0] rsVal;
	logic [31:0] rtVal;
	logic [31:0] immExt;
	logic [31:0] aluB;
	logic [31:0] aluResult;
	logic [63:0] rotWide;
	logic [31:0] wbData;
	logic [mipsPkg::DmemAw-1:0] dAddr;

	ctrlDecode i_decode (
		.op  (instr[31:26]),
		.func(instr[5:0]),
		.ctrl(ctrl)
	);

	assign fetchAddr = pc[mipsPkg::ImemAw+1:2];
	assign pcPlus4 = pc + 32'd4;
	assign retire = running && !full;

	////////////////////
	// Operands and ALU
	////////////////////
	assign rsVal = regFile[instr[25:21]];
	assign rtVal = regFile[instr[20:16]];
	assign immExt = ctrl.extSigned ? {{16{instr[15]}}, instr[15:0]} : {16'h0, instr[15:0]};
	assign aluB = ctrl.aluSrcImm ? immExt : rtVal;
	// Upper half of the doubled word is the left rotation
	assign rotWide = {rsVal, rsVal} << aluB[4:0];

	always_comb begin
		case (ctrl.aluOp)
			mipsPkg::AluSub: aluResult = rsVal - aluB;
			mipsPkg::AluOr:  aluResult = rsVal | aluB;
			mipsPkg::AluRot: aluResult = rotWide[63:32];
			default:         aluResult = rsVal + aluB;
		endcase
	end

	assign dAddr = aluResult[mipsPkg::DmemAw+1:2];

	always_comb begin
		case (ctrl.wbSel)
			mipsPkg::WbMem:  wbData = dmem[dAddr];
			mipsPkg::WbLui:  wbData = {instr[15:0], 16'h0};
			mipsPkg::WbLink: wbData = pcPlus4;
			default:         wbData = aluResult;
		endcase
		case (ctrl.regDst)
			mipsPkg::Rd: dest = instr[15:11];
			mipsPkg::Ra: dest = 5'd31;
			default:     dest = instr[20:16];
		endcase
	end

	// Branch offset is always sign extended
	always_comb begin
		case (ctrl.npcOp)
			mipsPkg::NpcBranch: nextPc = (rsVal == rtVal) ?
				pcPlus4 + {{14{instr[15]}}, instr[15:0], 2'b00} : pcPlus4;
			mipsPkg::NpcJump:   nextPc = {pcPlus4[31:28], instr[25:0], 2'b00};
			mipsPkg::NpcReg:    nextPc = rsVal;
			default:            nextPc = pcPlus4;
		endcase
	end

	////////////////////
	// State update
	////////////////////
	always_ff @(posedge clk) begin
		if (rst) begin
			pc <= '0;
			running <= 1'b0;
			done <= 1'b0;
		end else if (retire) begin
			pc <= nextPc;
			if (ctrl.halt) begin
				running <= 1'b0;
				done <= 1'b1;
			end
		end else if (start && !running && !done) begin
			pc <= '0;
			running <= 1'b1;
		end
	end

	// Register 0 is never written
	always_ff @(posedge clk) begin
		if (rst) begin
			for (int i = 0; i < 32; i++) regFile[i] <= '0;
		end else if (retire && ctrl.regWrite && dest != 5'd0) begin
			regFile[dest] <= wbData;
		end
	end

	always_ff @(posedge clk) begin
		if (retire && ctrl.memWrite) dmem[dAddr] <= rtVal;
	end

	////////////////////
	// Trace record
	////////////////////
	assign recValid = retire;

	always_comb begin
		rec = '0;
		rec.pc = pc;
		rec.instr = instr;
		rec.regWe = ctrl.regWrite && dest != 5'd0;
		if (rec.regWe) begin
			rec.regNum = dest;
			rec.regVal = wbData;
		end
		rec.memWe = ctrl.memWrite;
		if (ctrl.memWrite) begin
			rec.memAddr = aluResult;
			rec.memData = rtVal;
		end
	end

	// Halt is final until reset
	doneSticky: assert property (@(posedge clk) disable iff (rst) done |=> done && !running)
		else $error("execCore: core left the halted state");

endmodule

`default_nettype wire

/* verilog/retireQueue.sv */
`timescale 1ns/1ps
`default_nettype none

module retireQueue (
	input  logic           clk,
	input  logic           rst,
	input  logic           recValid,
	input  mipsPkg::traceT rec,
	output logic           full,
	input  logic           traceCredit,
	output logic           traceValid,
	output mipsPkg::traceT traceData
);

	mipsPkg::traceT fifo [mipsPkg::QueueDepth];
	logic [mipsPkg::QueueAw-1:0] wrPtr;
	logic [mipsPkg::QueueAw-1:0] rdPtr;
	logic [mipsPkg::QueueAw:0] count;
	logic [mipsPkg::CreditW-1:0] credits;
	logic push;
	logic pop;

	assign push = recValid;
	assign pop = traceValid;
	assign full = count == (mipsPkg::QueueAw + 1)'(mipsPkg::QueueDepth);

	// Head leaves only with data and a credit in hand
	assign traceValid = count != '0 && credits != '0;
	assign traceData = fifo[rdPtr];

	////////////////////
	// FIFO storage
	////////////////////
	always_ff @(posedge clk) begin
		if (push) fifo[wrPtr] <= rec;
	end

	// Depth is a power of two so pointers wrap on their own
	always_ff @(posedge clk) begin
		if (rst) begin
			wrPtr <= '0;
			rdPtr <= '0;
			count <= '0;
		end else begin
			if (push) wrPtr <= wrPtr + 1'b1;
			if (pop) rdPtr <= rdPtr + 1'b1;
			if (push && !pop) count <= count + 1'b1;
			else if (!push && pop) count <= count - 1'b1;
		end
	end

	////////////////////
	// Consumer credits
	////////////////////
	always_ff @(posedge clk) begin
		if (rst) credits <= '0;
		else if (traceCredit && !pop) credits <= credits + 1'b1;
		else if (!traceCredit && pop) credits <= credits - 1'b1;
	end

	// Producer must hold off while every slot is taken
	noPushWhenFull: assert property (@(posedge clk) disable iff (rst) push |-> !full)
		else $error("retireQueue: record pushed into a full queue");

	creditNoWrap: assert property (@(posedge clk) disable iff (rst)
		traceCredit && !pop |-> credits != '1)
		else $error("retireQueue: consumer credit count overflow");

endmodule

`default_nettype wire

/* verilog/mipsTop.sv */
`timescale 1ns/1ps
`default_nettype none

module mipsTop (
	input  logic              clk,
	input  logic              rst,
	input  logic              loadValid,
	input  mipsPkg::loadWordT loadWord,
	output logic              loadCredit,
	input  logic              start,
	input  logic              traceCredit,
	output logic              traceValid,
	output mipsPkg::traceT    traceData,
	output logic              done
);

	logic imemWe;
	logic [mipsPkg::ImemAw-1:0] imemAddr;
	logic [31:0] imemData;
	logic [mipsPkg::ImemAw-1:0] fetchAddr;
	logic [31:0] instr;
	logic recValid;
	mipsPkg::traceT rec;
	logic full;

	////////////////////
	// Instruction memory
	////////////////////
	logic [31:0] imem [mipsPkg::ImemWords];

	always_ff @(posedge clk) begin
		if (imemWe) imem[imemAddr] <= imemData;
	end

	// Asynchronous read for single-cycle fetch
	assign instr = imem[fetchAddr];

	progLoader i_loader (
		.clk       (clk),
		.rst       (rst),
		.loadValid (loadValid),
		.loadWord  (loadWord),
		.loadCredit(loadCredit),
		.imemWe    (imemWe),
		.imemAddr  (imemAddr),
		.imemData  (imemData)
	);

	execCore i_core (
		.clk      (clk),
		.rst      (rst),
		.start    (start),
		.full     (full),
		.instr    (instr),
		.fetchAddr(fetchAddr),
		.recValid (recValid),
		.rec      (rec),
		.done     (done)
	);

	retireQueue i_queue (
		.clk        (clk),
		.rst        (rst),
		.recValid   (recValid),
		.rec        (rec),
		.full       (full),
		.traceCredit(traceCredit),
		.traceValid (traceValid),
		.traceData  (traceData)
	);

endmodule

`default_nettype wire

/* include/isaModel.svh */
`ifndef ISA_MODEL_SVH
`define ISA_MODEL_SVH

// Architectural state of the reference model
logic [31:0] mPc;
logic [31:0] mReg [32];
logic [31:0] mMem [mipsPkg::DmemWords];
bit mHalted;

function automatic void modelReset();
	mPc = '0;
	mHalted = 1'b0;
	for (int i = 0; i < 32; i++)
		mReg[i] = '0;
	for (int i = 0; i < mipsPkg::DmemWords; i++)
		mMem[i] = '0;
endfunction

function automatic logic [31:0] rotl(input logic [31:0] v, input logic [4:0] n);
	if (n == 5'd0)
		return v;
	return (v << n) | (v >> (6'd32 - {1'b0, n}));
endfunction

////////////////////
// One instruction per call
////////////////////
function automatic mipsPkg::traceT isaStep();
	mipsPkg::traceT t;
	logic [31:0] ins;
	logic [31:0] a;
	logic [31:0] b;
	logic [31:0] sImm;
	logic [31:0] zImm;
	logic [31:0] pc4;
	logic [31:0] npc;
	logic [31:0] addr;
	logic wrEn;
	logic [4:0] wrNum;
	logic [31:0] wrVal;

	ins = progMem[mPc[mipsPkg::ImemAw+1:2]];
	a = mReg[ins[25:21]];
	b = mReg[ins[20:16]];
	sImm = {{16{ins[15]}}, ins[15:0]};
	zImm = {16'h0000, ins[15:0]};
	pc4 = mPc + 32'd4;
	npc = pc4;
	addr = a + sImm;
	wrEn = 1'b0;
	wrNum = ins[20:16];
	wrVal = '0;
	t = '0;
	t.pc = mPc;
	t.instr = ins;

	case (ins[31:26])
		mipsPkg::Special: begin
			wrNum = ins[15:11];
			case (ins[5:0])
				mipsPkg::Add: begin
					wrEn = 1'b1;
					wrVal = a + b;
				end
				mipsPkg::Sub: begin
					wrEn = 1'b1;
					wrVal = a - b;
				end
				mipsPkg::Jr: npc = a;
				default: ;
			endcase
		end
		mipsPkg::Ori: begin
			wrEn = 1'b1;
			wrVal = a | zImm;
		end
		mipsPkg::Lui: begin
			wrEn = 1'b1;
			wrVal = {ins[15:0], 16'h0000};
		end
		mipsPkg::Ras: begin
			wrEn = 1'b1;
			wrVal = rotl(a, ins[4:0]);
		end
		mipsPkg::Lw: begin
			wrEn = 1'b1;
			wrVal = mMem[addr[mipsPkg::DmemAw+1:2]];
		end
		mipsPkg::Sw: begin
			t.memWe = 1'b1;
			t.memAddr = addr;
			t.memData = b;
			mMem[addr[mipsPkg::DmemAw+1:2]] = b;
		end
		mipsPkg::Beq: begin
			if (a == b)
				npc = pc4 + {sImm[29:0], 2'b00};
		end
		mipsPkg::Jal: begin
			wrEn = 1'b1;
			wrNum = 5'd31;
			wrVal = pc4;
			npc = {pc4[31:28], ins[25:0], 2'b00};
		end
		mipsPkg::J: npc = {pc4[31:28], ins[25:0], 2'b00};
		mipsPkg::Halt: mHalted = 1'b1;
		default: ;
	endcase

	// Register 0 keeps its zero
	if (wrEn && wrNum != 5'd0) begin
		t.regWe = 1'b1;
		t.regNum = wrNum;
		t.regVal = wrVal;
		mReg[wrNum] = wrVal;
	end
	mPc = npc;
	return t;
endfunction

// Dry run to size the watchdog, leaves the model reset
function automatic int countSteps();
	int n;
	n = 0;
	modelReset();
	while (!mHalted && n < 1024) begin
		void'(isaStep());
		n++;
	end
	modelReset();
	return n;
endfunction

`endif

/* test/tbMips.sv */
`timescale 1ns/1ps
`default_nettype none

module tbMips;

	logic clk;
	logic rst;
	logic loadValid;
	mipsPkg::loadWordT loadWord;
	logic loadCredit;
	logic start;
	logic traceCredit;
	logic traceValid;
	mipsPkg::traceT traceData;
	logic done;

	logic [31:0] progMem [mipsPkg::ImemWords];
	int progLen;
	int execCount;
	int budgetCycles;
	bit budgetReady;
	bit haltSeen;
	bit failed;
	int creditsGiven;
	int beatsSeen;
	logic [31:0] rngState;

	`include "isaModel.svh"

	mipsTop i_dut (
		.clk        (clk),
		.rst        (rst),
		.loadValid  (loadValid),
		.loadWord   (loadWord),
		.loadCredit (loadCredit),
		.start      (start),
		.traceCredit(traceCredit),
		.traceValid (traceValid),
		.traceData  (traceData),
		.done       (done)
	);

	initial begin
		clk = 1'b0;
		forever #2 clk = ~clk;
	end

	function automatic logic [31:0] xorshift(input logic [31:0] x);
		logic [31:0] y;
		y = x ^ (x << 13);
		y = y ^ (y >> 17);
		y = y ^ (y << 5);
		return y;
	endfunction

	task automatic reportFail(input string msg);
		failed = 1'b1;
		$display("%s", msg);
		$display("ERRORS FOUND");
		$fatal(1);
	endtask

	////////////////////
	// Assembler helpers
	////////////////////
	function automatic logic [31:0] encR(input logic [5:0] fn, input logic [4:0] rs,
		input logic [4:0] rt, input logic [4:0] rd);
		return {6'b000000, rs, rt, rd, 5'd0, fn};
	endfunction

	function automatic logic [31:0] encI(input logic [5:0] op, input logic [4:0] rs,
		input logic [4:0] rt, input logic [15:0] imm);
		return {op, rs, rt, imm};
	endfunction

	function automatic logic [31:0] encJ(input logic [5:0] op, input logic [25:0] target);
		return {op, target};
	endfunction

	task automatic buildProgram();
		// Unused words hold a halt tagged with their own address
		for (int i = 0; i < mipsPkg::ImemWords; i++)
			progMem[i] = {mipsPkg::Halt, 26'(i)};
		progMem[0] = encI(mipsPkg::Ori, 5'd0, 5'd1, 16'h1234);
		progMem[1] = encI(mipsPkg::Lui, 5'd0, 5'd2, 16'h8000);
		progMem[2] = encR(mipsPkg::Add, 5'd1, 5'd2, 5'd3);
		progMem[3] = encR(mipsPkg::Sub, 5'd3, 5'd1, 5'd4);
		progMem[4] = encI(mipsPkg::Ras, 5'd3, 5'd5, 16'd4);
		// Write to r0 is dropped, then r0 is read
		progMem[5] = encI(mipsPkg::Ori, 5'd1, 5'd0, 16'hffff);
		progMem[6] = encR(mipsPkg::Add, 5'd0, 5'd1, 5'd6);
		progMem[7] = encI(mipsPkg::Ori, 5'd0, 5'd7, 16'h0040);
		progMem[8] = encI(mipsPkg::Sw, 5'd7, 5'd3, 16'hfffc);
		progMem[9] = encI(mipsPkg::Sw, 5'd7, 5'd5, 16'h0008);
		progMem[10] = encI(mipsPkg::Lw, 5'd7, 5'd8, 16'hfffc);
		progMem[11] = encI(mipsPkg::Lw, 5'd7, 5'd9, 16'h0008);
		// Taken branch skips word 13
		progMem[12] = encI(mipsPkg::Beq, 5'd8, 5'd3, 16'h0001);
		progMem[13] = encI(mipsPkg::Ori, 5'd0, 5'd10, 16'hdead);
		progMem[14] = encI(mipsPkg::Beq, 5'd8, 5'd1, 16'h0005);
		progMem[15] = encJ(mipsPkg::Jal, 26'd20);
		progMem[16] = encJ(mipsPkg::J, 26'd23);
		progMem[17] = encI(mipsPkg::Ori, 5'd0, 5'd10, 16'hbeef);
		progMem[18] = encI(mipsPkg::Ori, 5'd0, 5'd10, 16'hcafe);
		progMem[19] = encI(mipsPkg::Ori, 5'd0, 5'd10, 16'hf00d);
		progMem[20] = encI(mipsPkg::Ras, 5'd1, 5'd11, 16'd31);
		progMem[21] = encR(mipsPkg::Sub, 5'd11, 5'd6, 5'd12);
		progMem[22] = encR(mipsPkg::Jr, 5'd31, 5'd0, 5'd0);
		progMem[23] = encR(mipsPkg::Add, 5'd12, 5'd31, 5'd13);
		progMem[24] = {mipsPkg::Halt, 26'd0};
		progLen = 25;
	endtask

	// Sender spends a credit per beat and counts returned pulses
	task automatic loadProgram();
		int credits;
		int sent;
		credits = mipsPkg::LoadCredits;
		sent = 0;
		while (sent < progLen) begin
			@(negedge clk);
			if (credits > 0) begin
				loadValid = 1'b1;
				loadWord.addr = mipsPkg::ImemAw'(sent);
				loadWord.instr = progMem[sent];
				sent++;
				credits--;
			end else begin
				loadValid = 1'b0;
			end
			if (loadCredit)
				credits++;
			assert (credits <= mipsPkg::LoadCredits)
				else reportFail("The loader returned more credits than were spent");
		end
		@(negedge clk);
		loadValid = 1'b0;
		if (loadCredit)
			credits++;
		// All credits back means every word is in memory
		while (credits < mipsPkg::LoadCredits) begin
			@(negedge clk);
			if (loadCredit)
				credits++;
		end
	endtask

	task automatic checkRecord(input mipsPkg::traceT got, input mipsPkg::traceT exp);
		assert (got.pc == exp.pc)
			else reportFail($sformatf("ERROR at %0t: pc %h, expected %h", $time, got.pc, exp.pc));
		assert (got.instr == exp.instr)
			else reportFail($sformatf("ERROR at %0t: pc %h instr %h, expected %h",
				$time, got.pc, got.instr, exp.instr));
		assert (got.regWe == exp.regWe && got.regNum == exp.regNum && got.regVal == exp.regVal)
			else reportFail($sformatf("ERROR at %0t: pc %h reg %b r%0d=%h, expected %b r%0d=%h",
				$time, got.pc, got.regWe, got.regNum, got.regVal,
				exp.regWe, exp.regNum, exp.regVal));
		assert (got.memWe == exp.memWe && got.memAddr == exp.memAddr && got.memData == exp.memData)
			else reportFail($sformatf("ERROR at %0t: pc %h mem %b [%h]=%h, expected %b [%h]=%h",
				$time, got.pc, got.memWe, got.memAddr, got.memData,
				exp.memWe, exp.memAddr, exp.memData));
	endtask

	////////////////////
	// Main sequence
	////////////////////
	initial begin
		rst = 1'b1;
		loadValid = 1'b0;
		loadWord = '0;
		start = 1'b0;
		failed = 1'b0;
		haltSeen = 1'b0;
		budgetReady = 1'b0;
		buildProgram();
		execCount = countSteps();
		budgetCycles = 16 + 4 * progLen + 64 * execCount;
		budgetReady = 1'b1;
		repeat (16) @(posedge clk);
		@(negedge clk);
		rst = 1'b0;
		loadProgram();
		@(negedge clk);
		start = 1'b1;
		@(negedge clk);
		start = 1'b0;
		wait (haltSeen);
		// Quiet window with a credit banked to catch any record after the halt
		wait (creditsGiven > beatsSeen);
		repeat (4) @(negedge clk);
		assert (done)
			else reportFail("The done output dropped after the halt record");
		if (failed) begin
			$display("ERRORS FOUND");
			$fatal(1);
		end else begin
			$display("NO ERRORS");
			$finish;
		end
	end

	// Trace consumer with random credit gaps
	initial begin
		int drought;
		traceCredit = 1'b0;
		creditsGiven = 0;
		rngState = 32'ha1c1410c;
		wait (start == 1'b1);
		// Long initial gap fills the queue and stalls the core
		drought = 40;
		forever begin
			@(negedge clk);
			rngState = xorshift(rngState);
			if (drought > 0) begin
				drought--;
				traceCredit = 1'b0;
			end else if (rngState[7:0] < 8'd6) begin
				drought = int'(rngState[13:8]);
				traceCredit = 1'b0;
			end else begin
				traceCredit = (rngState[17:16] != 2'b00) && (creditsGiven - beatsSeen < 12);
			end
			if (traceCredit)
				creditsGiven <= creditsGiven + 1;
		end
	end

	// Comparison against the reference model
	initial begin
		mipsPkg::traceT exp;
		int recCount;
		beatsSeen = 0;
		recCount = 0;
		wait (rst == 1'b0);
		forever begin
			@(negedge clk);
			if (traceValid) begin
				assert (beatsSeen < creditsGiven)
					else reportFail("A trace record was sent without a granted credit");
				assert (!haltSeen)
					else reportFail("A trace record followed the halt record");
				exp = isaStep();
				if (recCount == 0) begin
					assert (traceData.pc == 32'd0 && traceData.instr == progMem[0])
						else reportFail($sformatf("ERROR at %0t: first record pc %h instr %h",
							$time, traceData.pc, traceData.instr));
				end
				checkRecord(traceData, exp);
				if (mHalted) begin
					haltSeen = 1'b1;
					assert (done)
						else reportFail("The halt record left before done was raised");
				end
				beatsSeen <= beatsSeen + 1;
				recCount++;
			end
		end
	end

	initial begin
		wait (budgetReady);
		repeat (budgetCycles) @(posedge clk);
		reportFail($sformatf("Watchdog expired after %0d cycles before the run finished",
			budgetCycles));
	end

endmodule

`default_nettype wire

/* sources.f */
+incdir+include
verilog/mipsPkg.sv
verilog/ctrlDecode.sv
verilog/progLoader.sv
verilog/execCore.sv
verilog/retireQueue.sv
verilog/mipsTop.sv
test/tbMips.sv

/* run.sh */
#!/usr/bin/env bash
# Build the testbench with Verilator, run it, then scan the log for the verdict
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log

verilator --binary --timing --assert -j 0 --top-module tbMips -f sources.f -o simMips \
	|| { echo "Verilator build failed"; exit 1; }

./obj_dir/simMips 2>&1 | tee sim.log

grep -q "ERRORS FOUND" sim.log && { echo "Simulation failed"; exit 1; }
grep -q "NO ERRORS" sim.log || { echo "Simulation ended without a verdict"; exit 1; }
echo "Simulation passed"
exit 0
